// ==== sources.f ====
+incdir+.
forth_pkg.sv
xt_if.sv
uart_rx.sv
uart_tx.sv
outer_interp.sv
inner_interp.sv
forth_core.sv
tb_forth_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the forth processor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_forth_core -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "run_sim: PASS"
else
	echo "run_sim: FAIL"
	exit 1
fi

// ==== tb_forth_core.sv ====
//////////////////////////////////////////////////
// testbench for the forth processor
// clock, reset, serial line driver
// tx frame monitor, reference model, compare
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "forth_settings.svh"

module tb_forth_core;

	localparam int frame_cycles = 10 * `CLKS_PER_BIT;
	// frames of quiet after a line end
	localparam int settle_frames = 3;
	localparam int timeout_cycles = 12 * 12 * 10 * `CLKS_PER_BIT + 2000;
	// "?" from the unknown word routine
	localparam logic [7:0] unknown_byte = 8'd63;

	// word classes of the reference model
	localparam int kind_unknown = 0;
	localparam int kind_red = 1;
	localparam int kind_gre = 2;
	localparam int kind_blu = 3;
	localparam int kind_led = 4;
	localparam int kind_del = 5;
	localparam int kind_digit = 6;

	logic clk = 1'b0;
	logic reset = 1'b0;
	logic rx = 1'b1;
	logic tx;
	logic led_r;
	logic led_g;
	logic led_b;

	// value view of the leds, bit 2 red, bit 1 blue, bit 0 green
	logic [2:0] leds_on;
	// stop bit and data byte per decoded frame
	logic [8:0] tx_frames [$];
	logic check_req = 1'b0;
	string check_name;
	logic [2:0] exp_leds;
	int exp_frames;
	logic [2:0] led_model = 3'b000;
	int errors = 0;
	int cycle_count = 0;

	assign leds_on = {!led_r, !led_b, !led_g};

	forth_core u_forth_core (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.tx    (tx),
		.led_r (led_r),
		.led_g (led_g),
		.led_b (led_b)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// first three chars equal, length up to the full word
	function automatic logic prefix_is(input string line, input int start, input int len,
		input string name, input int full_len);
		logic same;
		same = (len >= 3) && (len <= full_len);
		for (int k = 0; k < 3; k++) begin
			if (line[start + k] != name[k]) begin
				same = 1'b0;
			end
		end
		return same;
	endfunction

	function automatic int word_kind(input string line, input int start, input int len);
		int kind;
		kind = kind_unknown;
		if (prefix_is(line, start, len, "red", 3)) begin
			kind = kind_red;
		end else if (prefix_is(line, start, len, "gre", 5)) begin
			kind = kind_gre;
		end else if (prefix_is(line, start, len, "blu", 4)) begin
			kind = kind_blu;
		end else if (prefix_is(line, start, len, "led", 3)) begin
			kind = kind_led;
		end else if (prefix_is(line, start, len, "del", 3)) begin
			kind = kind_del;
		end else if ((len == 1) && (line[start] >= "0") && (line[start] <= "9")) begin
			kind = kind_digit;
		end
		return kind;
	endfunction

	// final led value after a line, last led word wins
	function automatic logic [2:0] expected_leds(input string line, input logic [2:0] prev);
		logic [2:0] v;
		logic [3:0] num;
		int start;
		int len;
		v = prev;
		num = '0;
		start = 0;
		for (int i = 0; i <= line.len(); i++) begin
			if ((i == line.len()) || (line[i] == " ")) begin
				len = i - start;
				if (len > 0) begin
					case (word_kind(line, start, len))
						kind_red: v = 3'd4;
						kind_gre: v = 3'd1;
						kind_blu: v = 3'd2;
						kind_digit: num = 4'(line[start] - "0");
						// top of stack to the leds
						kind_led: v = num[2:0];
						default: ;
					endcase
				end
				start = i + 1;
			end
		end
		return v;
	endfunction

	// one "?" frame per unknown word
	function automatic int expected_tx(input string line);
		int count;
		int start;
		count = 0;
		start = 0;
		for (int i = 0; i <= line.len(); i++) begin
			if ((i == line.len()) || (line[i] == " ")) begin
				if ((i > start) && (word_kind(line, start, i - start) == kind_unknown)) begin
					count++;
				end
				start = i + 1;
			end
		end
		return count;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//////////////////////////////////////////////////
	// serial driver and monitor
	//////////////////////////////////////////////////

	// 8N1, lsb first
	task automatic send_char(input logic [7:0] c);
		logic [9:0] frame;
		frame = {1'b1, c, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i];
			repeat (`CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic request_check(input string name, input logic [2:0] leds, input int frames);
		check_name = name;
		exp_leds = leds;
		exp_frames = frames;
		@(posedge clk);
		check_req <= 1'b1;
		@(posedge clk);
		check_req <= 1'b0;
		@(posedge clk);
	endtask

	// type a line with cr, let it run, then compare
	task automatic run_line(input string line);
		for (int i = 0; i < line.len(); i++) begin
			send_char(line[i]);
		end
		send_char(8'd13);
		repeat (settle_frames * frame_cycles) @(posedge clk);
		led_model = expected_leds(line, led_model);
		request_check(line, led_model, expected_tx(line));
	endtask

	initial begin : tx_monitor
		logic [7:0] data;
		logic stop_bit;
		forever begin
			@(negedge tx);
			// middle of the start bit
			repeat (`CLKS_PER_BIT / 2) @(posedge clk);
			if (tx == 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (`CLKS_PER_BIT) @(posedge clk);
					data[i] = tx;
				end
				repeat (`CLKS_PER_BIT) @(posedge clk);
				stop_bit = tx;
				tx_frames.push_back({stop_bit, data});
			end
		end
	end

	//////////////////////////////////////////////////
	// compare
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (check_req) begin
			assert (leds_on == exp_leds) else begin
				$display("[ERROR] %s: leds expected %03b, actual %03b",
					check_name, exp_leds, leds_on);
				errors++;
			end
			assert (tx_frames.size() == exp_frames) else begin
				$display("[ERROR] %s: tx frames expected %0d, actual %0d",
					check_name, exp_frames, tx_frames.size());
				errors++;
			end
			for (int i = 0; i < tx_frames.size(); i++) begin
				assert (tx_frames[i][7:0] == unknown_byte) else begin
					$display("[ERROR] %s: tx byte expected %02h, actual %02h",
						check_name, unknown_byte, tx_frames[i][7:0]);
					errors++;
				end
				assert (tx_frames[i][8] == 1'b1) else begin
					$display("Stop bit low in a tx frame during %s", check_name);
					errors++;
				end
			end
			// line idles high between frames
			assert (tx == 1'b1) else begin
				$display("[ERROR] %s: tx idle expected 1, actual %0b", check_name, tx);
				errors++;
			end
			tx_frames.delete();
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] rnd;
		int digit;
		rnd = 32'd37;
		// reset low for three edges
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		request_check("reset", 3'b000, 0);

		// one colour word per line
		run_line("red");
		run_line("gre");
		run_line("blu");
		// longer words hit by prefix
		run_line("green");
		run_line("blue");

		// digit then led
		run_line("5 led");
		run_line("0 led");
		for (int n = 0; n < 3; n++) begin
			rnd = xorshift(rnd);
			digit = int'(rnd % 10);
			run_line($sformatf("%0d led", digit));
		end

		// unknown word sends ?
		run_line("xyz");
		// tokens run in order through the delay
		run_line("red del gre");

		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== forth_core.sv ====
//////////////////////////////////////////////////
// forth processor top level
// serial links and both interpreters
//////////////////////////////////////////////////

`timescale 1ns/100ps

module forth_core (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);
	logic [7:0] rx_byte;
	logic rx_valid;
	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	// tokens from outer to inner interpreter
	xt_if u_xt ();

	uart_rx u_uart_rx (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	outer_interp u_outer (
		.clk      (clk),
		.reset    (reset),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.xt_port  (u_xt.outer)
	);

	inner_interp u_inner (
		.clk      (clk),
		.reset    (reset),
		.xt_port  (u_xt.inner),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.led_r    (led_r),
		.led_g    (led_g),
		.led_b    (led_b)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

// ==== inner_interp.sv ====
//////////////////////////////////////////////////
// inner interpreter
// boot rom image, data stack
// fetch and execute engine, led and emit control
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "forth_settings.svh"

module inner_interp
	import forth_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	xt_if.inner        xt_port,
	output logic [7:0] tx_byte,
	output logic       tx_start,
	input  logic       tx_busy,
	output logic       led_r,
	output logic       led_g,
	output logic       led_b
);
	localparam int sp_w = $clog2(`DSTACK_DEPTH);
	localparam logic [`CELL_WIDTH-1:0] true_cell = '1;
	localparam logic [`CELL_WIDTH-1:0] false_cell = '0;

	localparam logic [1:0] s_fetch = 2'd0;
	localparam logic [1:0] s_operand = 2'd1;
	localparam logic [1:0] s_emit = 2'd2;

	//////////////////////////////////////////////////
	// boot rom image
	//////////////////////////////////////////////////

	function automatic cell_u boot_cell(input logic [`ADDR_WIDTH-1:0] addr);
		cell_u c;
		c.value = '0;
		case (addr)
			0: c.op_view.op = op_execute;
			// unknown word prints ?
			1: c.op_view.op = op_lit;
			2: c.value = `CELL_WIDTH'(63);
			3: c.op_view.op = op_emit;
			4: c.op_view.op = op_branch;
			// red
			6: c.op_view.op = op_lit;
			7: c.value = `CELL_WIDTH'(4);
			8: c.op_view.op = op_io_led;
			9: c.op_view.op = op_branch;
			// green
			11: c.op_view.op = op_lit;
			12: c.value = `CELL_WIDTH'(1);
			13: c.op_view.op = op_io_led;
			14: c.op_view.op = op_branch;
			// blue
			16: c.op_view.op = op_lit;
			17: c.value = `CELL_WIDTH'(2);
			18: c.op_view.op = op_io_led;
			19: c.op_view.op = op_branch;
			// parsed digit
			21: c.op_view.op = op_number;
			22: c.op_view.op = op_branch;
			// led word
			24: c.op_view.op = op_io_led;
			25: c.op_view.op = op_branch;
			// del countdown
			27: c.op_view.op = op_lit;
			28: c.value = `CELL_WIDTH'(`DELAY_COUNT);
			29: c.op_view.op = op_lit;
			30: c.value = `CELL_WIDTH'(1);
			31: c.op_view.op = op_minus;
			32: c.op_view.op = op_dup;
			33: c.op_view.op = op_zero_equal;
			34: c.op_view.op = op_zbranch;
			35: c.value = `CELL_WIDTH'(29);
			36: c.op_view.op = op_drop;
			37: c.op_view.op = op_branch;
			// branch targets back to 0 stay zero
			default: c.value = '0;
		endcase
		return c;
	endfunction

	cell_u rom [`ROM_DEPTH];
	logic [`CELL_WIDTH-1:0] dstack [`DSTACK_DEPTH];
	// item count, one wider than the index
	logic [sp_w:0] dsp;
	logic [sp_w-1:0] push_idx;
	logic [sp_w-1:0] top_idx;
	logic [sp_w-1:0] nos_idx;
	logic [`CELL_WIDTH-1:0] tos;
	logic [`CELL_WIDTH-1:0] nos;
	xt_t pc;
	logic [1:0] state;
	op_e cur_op;
	op_e pending_op;
	logic take_branch;
	logic [`CELL_WIDTH-1:0] operand;

	assign push_idx = dsp[sp_w-1:0];
	assign top_idx = push_idx - 1'b1;
	assign nos_idx = push_idx - 2'd2;
	assign tos = dstack[top_idx];
	assign nos = dstack[nos_idx];

	// the same cell seen two ways
	assign cur_op = rom[pc].op_view.op;
	assign operand = rom[pc].value;

	// pop the token in the cycle the jump happens
	assign xt_port.xt_take = (state == s_fetch) && (cur_op == op_execute) && xt_port.xt_valid;

	//////////////////////////////////////////////////
	// fetch and execute
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `ROM_DEPTH; i++) begin
				rom[i] <= boot_cell(`ADDR_WIDTH'(i));
			end
			pc <= '0;
			dsp <= '0;
			state <= s_fetch;
			pending_op <= op_execute;
			take_branch <= 1'b0;
			tx_start <= 1'b0;
			led_r <= 1'b1;
			led_g <= 1'b1;
			led_b <= 1'b1;
		end else begin
			case (state)
				s_fetch: begin
					pc <= pc + 1'b1;
					case (cur_op)
						op_execute: begin
							// hold until a token shows up
							if (xt_port.xt_valid) begin
								pc <= xt_port.xt;
							end else begin
								pc <= pc;
							end
						end
						op_lit, op_branch: begin
							pending_op <= cur_op;
							state <= s_operand;
						end
						op_zbranch: begin
							pending_op <= cur_op;
							take_branch <= tos == '0;
							dsp <= dsp - 1'b1;
							state <= s_operand;
						end
						op_number: begin
							dstack[push_idx] <= xt_port.number;
							dsp <= dsp + 1'b1;
						end
						op_plus: begin
							dstack[nos_idx] <= nos + tos;
							dsp <= dsp - 1'b1;
						end
						op_minus: begin
							dstack[nos_idx] <= nos - tos;
							dsp <= dsp - 1'b1;
						end
						op_dup: begin
							dstack[push_idx] <= tos;
							dsp <= dsp + 1'b1;
						end
						op_drop: dsp <= dsp - 1'b1;
						op_over: begin
							dstack[push_idx] <= nos;
							dsp <= dsp + 1'b1;
						end
						op_equal: begin
							dstack[nos_idx] <= (nos == tos) ? true_cell : false_cell;
							dsp <= dsp - 1'b1;
						end
						op_zero_equal: dstack[top_idx] <= (tos == '0) ? true_cell : false_cell;
						op_and: begin
							dstack[nos_idx] <= nos & tos;
							dsp <= dsp - 1'b1;
						end
						op_or: begin
							dstack[nos_idx] <= nos | tos;
							dsp <= dsp - 1'b1;
						end
						op_emit: begin
							// wait out a frame still on the line
							if (tx_busy) begin
								pc <= pc;
							end else begin
								tx_byte <= tos[7:0];
								tx_start <= 1'b1;
								dsp <= dsp - 1'b1;
								state <= s_emit;
							end
						end
						op_io_led: begin
							// leds are active low
							led_g <= ~tos[0];
							led_b <= ~tos[1];
							led_r <= ~tos[2];
							dsp <= dsp - 1'b1;
						end
						default: ;
					endcase
				end
				s_operand: begin
					// second cycle of lit and branches
					state <= s_fetch;
					if (pending_op == op_lit) begin
						dstack[push_idx] <= operand;
						dsp <= dsp + 1'b1;
						pc <= pc + 1'b1;
					end else if ((pending_op == op_branch) || take_branch) begin
						pc <= operand[`ADDR_WIDTH-1:0];
					end else begin
						pc <= pc + 1'b1;
					end
				end
				default: begin
					tx_start <= 1'b0;
					// busy rises one cycle after the start pulse
					if (!tx_start && !tx_busy) begin
						state <= s_fetch;
					end
				end
			endcase
		end
	end

	// stack count stays inside the stack
	a_dsp_range: assert property (@(posedge clk) disable iff (!reset)
		dsp <= (sp_w + 1)'(`DSTACK_DEPTH));

	// no new frame while the transmitter is busy
	a_tx_start_idle: assert property (@(posedge clk) disable iff (!reset)
		$rose(tx_start) |-> !tx_busy);

endmodule

// ==== outer_interp.sv ====
//////////////////////////////////////////////////
// outer interpreter
// word parser and dictionary search
// single digit numbers, token queue per line
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "forth_settings.svh"

module outer_interp
	import forth_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] rx_byte,
	input  logic       rx_valid,
	xt_if.outer        xt_port
);
	localparam int q_w = $clog2(`XT_QUEUE_DEPTH);
	localparam int n_dict = 5;

	localparam logic [1:0] s_collect = 2'd0;
	localparam logic [1:0] s_search = 2'd1;
	localparam logic [1:0] s_execute = 2'd2;

	// dictionary, three char prefix plus full word length
	localparam logic [23:0] dict_name [n_dict] = '{"red", "gre", "blu", "led", "del"};
	localparam logic [2:0] dict_len [n_dict] = '{3'd3, 3'd5, 3'd4, 3'd3, 3'd3};
	localparam xt_t dict_xt [n_dict] = '{xt_t'(6), xt_t'(11), xt_t'(16), xt_t'(24), xt_t'(27)};

	// rom routines for numbers and unknown words
	localparam xt_t xt_number = xt_t'(21);
	localparam xt_t xt_unknown = xt_t'(1);

	logic [1:0] state;
	logic [2:0] word_len;
	logic [23:0] word_chars;
	logic line_end;
	logic [2:0] dict_idx;
	xt_t xt_queue [`XT_QUEUE_DEPTH];
	logic [q_w:0] wr_ptr;
	logic [q_w:0] rd_ptr;
	logic is_eol;
	logic is_space;
	logic word_hit;
	logic is_digit;
	xt_t new_xt;

	// cr, lf, vt, ff all end a line
	assign is_eol = (rx_byte >= 8'd10) && (rx_byte <= 8'd13);
	assign is_space = rx_byte == 8'h20;

	// prefix must match, length may run up to the full word
	assign word_hit = (word_chars == dict_name[dict_idx]) && (word_len <= dict_len[dict_idx]);
	assign is_digit = (word_len == 3'd1) && (word_chars[23:16] >= "0")
		&& (word_chars[23:16] <= "9");
	assign new_xt = word_hit ? dict_xt[dict_idx] : (is_digit ? xt_number : xt_unknown);

	// queue head shown only while executing
	assign xt_port.xt_valid = (state == s_execute) && (rd_ptr != wr_ptr);
	assign xt_port.xt = xt_queue[rd_ptr[q_w-1:0]];

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= s_collect;
			word_len <= '0;
			word_chars <= '0;
			line_end <= 1'b0;
			dict_idx <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			case (state)
				s_collect: begin
					if (rx_valid && (is_eol || is_space)) begin
						line_end <= is_eol;
						dict_idx <= '0;
						// skip empty words
						if (word_len != 3'd0) begin
							state <= s_search;
						end else if (is_eol) begin
							state <= s_execute;
						end
					end else if (rx_valid) begin
						// keep the first three chars
						case (word_len)
							3'd0: word_chars[23:16] <= rx_byte;
							3'd1: word_chars[15:8] <= rx_byte;
							3'd2: word_chars[7:0] <= rx_byte;
							default: ;
						endcase
						// saturating length
						if (word_len != 3'd7) begin
							word_len <= word_len + 1'b1;
						end
					end
				end
				s_search: begin
					// one entry per cycle
					if (word_hit || (dict_idx == 3'(n_dict - 1))) begin
						// extra tokens beyond the queue are lost
						if (wr_ptr < (q_w + 1)'(`XT_QUEUE_DEPTH)) begin
							xt_queue[wr_ptr[q_w-1:0]] <= new_xt;
							wr_ptr <= wr_ptr + 1'b1;
						end
						if (!word_hit && is_digit) begin
							xt_port.number <= {{(`CELL_WIDTH - 4){1'b0}}, word_chars[19:16]};
						end
						word_len <= '0;
						word_chars <= '0;
						state <= line_end ? s_execute : s_collect;
					end else begin
						dict_idx <= dict_idx + 1'b1;
					end
				end
				default: begin
					// incoming chars are dropped here
					if (xt_port.xt_take) begin
						rd_ptr <= rd_ptr + 1'b1;
					end else if (rd_ptr == wr_ptr) begin
						rd_ptr <= '0;
						wr_ptr <= '0;
						state <= s_collect;
					end
				end
			endcase
		end
	end

endmodule

// ==== uart_tx.sv ====
//////////////////////////////////////////////////
// serial transmitter, 8N1
// frame shifter with busy level
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "forth_settings.svh"

module uart_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx,
	output logic       tx_busy
);
	localparam int cnt_w = $clog2(`CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`CLKS_PER_BIT - 1);

	// data bits then stop bit
	logic [8:0] frame;
	logic [3:0] bit_cnt;
	logic [cnt_w-1:0] clk_cnt;

	always_ff @(posedge clk) begin
		if (!reset) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// start bit goes out right away
				tx <= 1'b0;
				frame <= {1'b1, tx_byte};
				tx_busy <= 1'b1;
				bit_cnt <= '0;
				clk_cnt <= '0;
			end
		end else if (clk_cnt == last_cnt) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				// ten bit times done
				tx <= 1'b1;
				tx_busy <= 1'b0;
			end else begin
				tx <= frame[0];
				frame <= {1'b1, frame[8:1]};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

// ==== uart_rx.sv ====
//////////////////////////////////////////////////
// serial receiver, 8N1
// start detect, mid bit sampling, byte strobe
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "forth_settings.svh"

module uart_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);
	localparam int cnt_w = $clog2(`CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`CLKS_PER_BIT - 1);
	localparam logic [cnt_w-1:0] half_cnt = cnt_w'(`CLKS_PER_BIT / 2 - 1);

	localparam logic [1:0] s_idle = 2'd0;
	localparam logic [1:0] s_start = 2'd1;
	localparam logic [1:0] s_data = 2'd2;
	localparam logic [1:0] s_stop = 2'd3;

	logic [1:0] rx_sync;
	logic [1:0] state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	// byte is complete when the strobe fires
	assign rx_byte = shift;

	always_ff @(posedge clk) begin
		if (!reset) begin
			rx_sync <= 2'b11;
			state <= s_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			case (state)
				s_idle: begin
					// falling start edge
					if (!rx_sync[1]) begin
						clk_cnt <= '0;
						state <= s_start;
					end
				end
				s_start: begin
					if (clk_cnt == half_cnt) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch check at mid start bit
						state <= rx_sync[1] ? s_idle : s_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				s_data: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						// lsb first
						shift <= {rx_sync[1], shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= s_stop;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						// framing error drops the byte
						rx_valid <= rx_sync[1];
						state <= s_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// the byte strobe never stretches
	a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!reset)
		rx_valid |=> !rx_valid);

endmodule

// ==== xt_if.sv ====
//////////////////////////////////////////////////
// token link between the two interpreters
// head token, valid level, take pulse, number
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "forth_settings.svh"

interface xt_if
	import forth_pkg::*;
();
	// high while execute phase has tokens left
	logic xt_valid;
	// head of the token queue
	xt_t xt;
	// last parsed digit
	logic [`CELL_WIDTH-1:0] number;
	// pops the head, one cycle
	logic xt_take;

	modport outer (output xt_valid, output xt, output number, input xt_take);
	modport inner (input xt_valid, input xt, input number, output xt_take);

endinterface

// ==== forth_pkg.sv ====
//////////////////////////////////////////////////
// shared forth types
// opcode enumeration, rom cell union, token type
//////////////////////////////////////////////////

`include "forth_settings.svh"

package forth_pkg;

	// inner interpreter opcodes
	// execute must stay at code zero
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		op_execute,
		op_lit,
		op_number,
		op_branch,
		op_zbranch,
		op_plus,
		op_minus,
		op_dup,
		op_drop,
		op_over,
		op_equal,
		op_zero_equal,
		op_and,
		op_or,
		op_emit,
		op_io_led
	} op_e;

	// one rom cell, read as an operation or as a raw value
	// literal and branch target cells use the value view
	typedef union packed {
		struct packed {
			logic [`CELL_WIDTH-`OPCODE_WIDTH-1:0] upper;
			op_e op;
		} op_view;
		logic [`CELL_WIDTH-1:0] value;
	} cell_u;

	// execution token, a rom address
	typedef logic [`ADDR_WIDTH-1:0] xt_t;

endpackage

// ==== forth_settings.svh ====
//////////////////////////////////////////////////
// global sizes for the forth processor
// stack, rom and token queue depths
// serial bit timing and delay loop count
//////////////////////////////////////////////////

`ifndef FORTH_SETTINGS_SVH
`define FORTH_SETTINGS_SVH

// data stack and rom cell
`define CELL_WIDTH 32
`define OPCODE_WIDTH 16
`define DSTACK_DEPTH 16

// boot rom
`define ROM_DEPTH 64
`define ADDR_WIDTH 6

// tokens per typed line
`define XT_QUEUE_DEPTH 8

// serial link, clocks per bit
`define CLKS_PER_BIT 16

// start value of the del countdown
`define DELAY_COUNT 20

`endif
